//--- runSim.sh
#!/bin/sh
# Build the simulation with Verilator, run it into a log and look for the pass line

verilator --binary --timing --assert -f vlog.f --top-module midpointTb -o midpointSim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/midpointSim > sim.log 2>&1
cat sim.log

grep -q '^\*\* PASS \*\*$' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- source/debounceTimer.sv
// ----------------------------------------------------------
// Debounce timer, counts consecutive cycles of disagreement
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module debounceTimer (
  input  logic trigger,
  input  logic rstN,
  input  logic mismatch,  // Synchronized input differs from accepted level
  output logic expired    // Disagreement has lasted long enough
);

  midpointPkg::debounceCountT count;

  // Count has hit the limit and the input still disagrees
  assign expired = mismatch &&
                   (count == midpointPkg::debounceCountT'(midpointPkg::DebounceCycles));

  always_ff @(posedge trigger or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (!mismatch || expired) begin
      // Bounce back or accepted level flips, start over
      count <= '0;
    end else begin
      count <= count + 1'b1;  // Another cycle of disagreement
    end
  end

endmodule

`default_nettype wire

//--- source/displayDriver.sv
// ----------------------------------------------------------
// LED driver, selects one nibble of the register to show
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module displayDriver (
  input  logic                trigger,
  input  logic                rstN,
  input  logic                showHigh,  // Sets the select flop
  input  logic                showLow,   // Clears the select flop
  input  midpointPkg::byteT   value,     // Register contents
  output midpointPkg::nibbleT leds
);

  logic showLowNibble;  // 1 shows bits 3..0, 0 shows bits 4..7 reversed

  // JK-style select flop
  always_ff @(posedge trigger or negedge rstN) begin
    if (!rstN) begin
      showLowNibble <= 1'b0;
    end else begin
      case ({showHigh, showLow})
        2'b10:   showLowNibble <= 1'b1;            // Set
        2'b01:   showLowNibble <= 1'b0;            // Clear
        2'b11:   showLowNibble <= ~showLowNibble;  // Toggle
        default: showLowNibble <= showLowNibble;   // Hold
      endcase
    end
  end

  // LED 0 carries bit 7 in the reversed view, as wired on the board
  assign leds = showLowNibble ? value[3:0]
                              : {value[4], value[5], value[6], value[7]};

endmodule

`default_nettype wire

//--- source/inputConditioner.sv
// ----------------------------------------------------------
// Input conditioner, synchronizes and debounces one input
// and produces single-cycle rise and fall strobes
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module inputConditioner (
  input  logic                     trigger,
  input  logic                     rstN,
  input  logic                     rawIn,        // Mechanical button or switch
  output midpointPkg::conditionedT conditioned
);

  logic [1:0] syncQ;     // Two-flop synchronizer, bit 1 is the output
  logic       mismatch;  // Synchronized value disagrees with accepted level
  logic       expired;   // Timer says the disagreement is real

  // ----------------------------------------------------------
  // Synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge trigger or negedge rstN) begin
    if (!rstN) begin
      syncQ <= '0;
    end else begin
      syncQ <= {syncQ[0], rawIn};  // Shift raw input through both stages
    end
  end

  assign mismatch = syncQ[1] ^ conditioned.level;

  // ----------------------------------------------------------
  // Stability timer
  // ----------------------------------------------------------
  debounceTimer timer (
    .trigger  (trigger),
    .rstN     (rstN),
    .mismatch (mismatch),
    .expired  (expired)
  );

  // ----------------------------------------------------------
  // Accepted level and edge strobes
  // ----------------------------------------------------------
  always_ff @(posedge trigger or negedge rstN) begin
    if (!rstN) begin
      conditioned <= '0;
    end else begin
      // Strobes default low, so each lasts exactly one cycle
      conditioned.rise <= 1'b0;
      conditioned.fall <= 1'b0;
      if (expired) begin
        conditioned.level <= ~conditioned.level;  // Take the new level
        conditioned.rise  <= ~conditioned.level;  // Was 0, now 1
        conditioned.fall  <= conditioned.level;   // Was 1, now 0
      end
    end
  end

endmodule

`default_nettype wire

//--- source/midpointPkg.sv
// ----------------------------------------------------------
// Shared widths, debounce length and conditioner output type
// ----------------------------------------------------------
`default_nettype none

package midpointPkg;

  // ----------------------------------------------------------
  // Widths and timing
  // ----------------------------------------------------------
  localparam int unsigned ByteWidth      = 8;  // Shift register width
  localparam int unsigned NibbleWidth    = 4;  // One LED bank
  localparam int unsigned DebounceCycles = 4;  // Stable cycles before a new level is taken

  // Register and LED vectors
  typedef logic [ByteWidth-1:0]   byteT;
  typedef logic [NibbleWidth-1:0] nibbleT;

  // Timer count must reach DebounceCycles itself, hence the extra bit
  typedef logic [$clog2(DebounceCycles + 1)-1:0] debounceCountT;

  // Clean level plus single-cycle edge strobes
  typedef struct packed {
    logic level;  // Accepted level
    logic rise;   // Level just went 0 -> 1
    logic fall;   // Level just went 1 -> 0
  } conditionedT;

endpackage

`default_nettype wire

//--- source/midpointTop.sv
// ----------------------------------------------------------
// Serial capture top, five conditioners feed the shift
// register, which feeds the LED display driver
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module midpointTop (
  input  logic                trigger,
  input  logic                rstN,
  input  logic                loadButton,      // Parallel load request
  input  logic                serialSwitch,    // Serial data level
  input  logic                sclkSwitch,      // Serial clock
  input  logic                showHighButton,  // Selects bits 3..0 on LEDs
  input  logic                showLowButton,   // Selects bits 4..7 reversed
  input  midpointPkg::byteT   loadValue,
  output midpointPkg::nibbleT leds,
  output midpointPkg::byteT   registerValue,
  output logic                serialOut
);

  // Conditioned versions of each board input
  midpointPkg::conditionedT loadCond;
  midpointPkg::conditionedT dataCond;
  midpointPkg::conditionedT sclkCond;
  midpointPkg::conditionedT showHighCond;
  midpointPkg::conditionedT showLowCond;

  // ----------------------------------------------------------
  // Input conditioners
  // ----------------------------------------------------------
  inputConditioner loadIc     (.trigger(trigger), .rstN(rstN), .rawIn(loadButton),
                               .conditioned(loadCond));
  inputConditioner dataIc     (.trigger(trigger), .rstN(rstN), .rawIn(serialSwitch),
                               .conditioned(dataCond));
  inputConditioner sclkIc     (.trigger(trigger), .rstN(rstN), .rawIn(sclkSwitch),
                               .conditioned(sclkCond));
  inputConditioner showHighIc (.trigger(trigger), .rstN(rstN), .rawIn(showHighButton),
                               .conditioned(showHighCond));
  inputConditioner showLowIc  (.trigger(trigger), .rstN(rstN), .rawIn(showLowButton),
                               .conditioned(showLowCond));

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  shiftRegister shifter (
    .trigger   (trigger),
    .rstN      (rstN),
    .load      (loadCond.rise),   // Button press loads
    .shift     (sclkCond.rise),   // Clock switch going up shifts
    .loadValue (loadValue),
    .serialIn  (dataCond.level),
    .value     (registerValue),
    .serialOut (serialOut)
  );

  displayDriver display (
    .trigger  (trigger),
    .rstN     (rstN),
    .showHigh (showHighCond.level),
    .showLow  (showLowCond.level),
    .value    (registerValue),
    .leds     (leds)
  );

endmodule

`default_nettype wire

//--- source/shiftRegister.sv
// ----------------------------------------------------------
// 8-bit shift register with parallel load and serial shift
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shiftRegister (
  input  logic              trigger,
  input  logic              rstN,
  input  logic              load,       // Parallel load strobe
  input  logic              shift,      // Serial clock strobe
  input  midpointPkg::byteT loadValue,  // Value taken on load
  input  logic              serialIn,   // Bit entering at position 0
  output midpointPkg::byteT value,      // Current register contents
  output logic              serialOut   // Registered MSB for the serial line
);

  midpointPkg::byteT nextValue;

  // ----------------------------------------------------------
  // Next-state selection, load wins over shift
  // ----------------------------------------------------------
  always_comb begin
    nextValue = value;  // Hold by default
    if (load) begin
      nextValue = loadValue;
    end else if (shift) begin
      // Move left, new bit fills the bottom
      nextValue = {value[midpointPkg::ByteWidth-2:0], serialIn};
    end
  end

  // ----------------------------------------------------------
  // Register and serial output flop
  // ----------------------------------------------------------
  always_ff @(posedge trigger or negedge rstN) begin
    if (!rstN) begin
      value     <= '0;
      serialOut <= 1'b0;
    end else begin
      value     <= nextValue;
      serialOut <= nextValue[midpointPkg::ByteWidth-1];  // Tracks the MSB
    end
  end

endmodule

`default_nettype wire

//--- verification/midpointTb.sv
// ----------------------------------------------------------
// Testbench for the serial capture top that drives the board
// inputs and checks register, serial line and LEDs
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module midpointTb;

  // Sync, debounce and register update plus a spare cycle
  localparam int unsigned SettleCycles = midpointPkg::DebounceCycles + 5;
  localparam int unsigned StepTotal    = 48;  // Input changes over all tests plus slack
  localparam int unsigned TimeLimitNs  = StepTotal * (midpointPkg::DebounceCycles + 4) * 4 * 2;

  logic                trigger;
  logic                rstN;
  logic                loadButton;
  logic                serialSwitch;
  logic                sclkSwitch;
  logic                showHighButton;
  logic                showLowButton;
  midpointPkg::byteT   loadValue;
  midpointPkg::nibbleT leds;
  midpointPkg::byteT   registerValue;
  logic                serialOut;

  // Reference model
  midpointPkg::byteT expValue;   // Expected register contents
  logic              expSelect;  // 1 shows bits 3..0

  integer seed       = 78;
  int     checkCount = 0;
  int     errorCount = 0;
  int     markChecks = 0;  // Totals when the current test began
  int     markErrors = 0;
  logic   newBit;

  midpointTop DUT (
    .trigger        (trigger),
    .rstN           (rstN),
    .loadButton     (loadButton),
    .serialSwitch   (serialSwitch),
    .sclkSwitch     (sclkSwitch),
    .showHighButton (showHighButton),
    .showLowButton  (showLowButton),
    .loadValue      (loadValue),
    .leds           (leds),
    .registerValue  (registerValue),
    .serialOut      (serialOut)
  );

  bind midpointTop midpointTopChk chk (
    .trigger       (trigger),
    .rstN          (rstN),
    .loadCond      (loadCond),
    .dataCond      (dataCond),
    .sclkCond      (sclkCond),
    .showHighCond  (showHighCond),
    .showLowCond   (showLowCond),
    .loadValue     (loadValue),
    .registerValue (registerValue)
  );

  initial begin
    trigger = 1'b0;
    forever #2 trigger = ~trigger;  // 4 ns period
  end

  // Watchdog
  initial begin
    #(TimeLimitNs);
    $display("Simulation timed out before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic settle();
    repeat (SettleCycles) @(negedge trigger);  // Long enough for any change to be accepted
  endtask

  function automatic midpointPkg::nibbleT expectedLeds();
    if (expSelect) begin
      return expValue[midpointPkg::NibbleWidth-1:0];
    end
    // High nibble with bit 7 on LED 0
    return {<<{expValue[midpointPkg::ByteWidth-1:midpointPkg::NibbleWidth]}};
  endfunction

  task automatic checkOutputs(input string what);
    midpointPkg::nibbleT expLeds;
    expLeds    = expectedLeds();
    checkCount += 3;
    assert (registerValue == expValue) else begin
      $display("Error at %0t: %s, registerValue %h, expected %h", $time, what,
               registerValue, expValue);
      errorCount++;
    end
    assert (serialOut == expValue[midpointPkg::ByteWidth-1]) else begin
      $display("Error at %0t: %s, serialOut %b, expected %b", $time, what,
               serialOut, expValue[midpointPkg::ByteWidth-1]);
      errorCount++;
    end
    assert (leds == expLeds) else begin
      $display("Error at %0t: %s, leds %b, expected %b", $time, what, leds, expLeds);
      errorCount++;
    end
  endtask

  task automatic finishTest(input string name);
    $display("Test %s finished, %0d checks, %0d errors", name,
             checkCount - markChecks, errorCount - markErrors);
    markChecks = checkCount;
    markErrors = errorCount;
  endtask

  task automatic pressLoad(input midpointPkg::byteT value);
    loadValue  = value;
    loadButton = 1'b1;
    settle();
    expValue = value;
    checkOutputs("load press");
    loadButton = 1'b0;
    settle();
    checkOutputs("load release");  // Release edge loads nothing
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    rstN           = 1'b0;
    loadButton     = 1'b0;
    serialSwitch   = 1'b0;
    sclkSwitch     = 1'b0;
    showHighButton = 1'b0;
    showLowButton  = 1'b0;
    loadValue      = '0;
    expValue       = '0;
    expSelect      = 1'b0;
    newBit         = 1'b0;
    repeat (2) @(posedge trigger);
    @(negedge trigger);
    rstN = 1'b1;

    checkOutputs("after reset");
    finishTest("reset");

    repeat (4) pressLoad(midpointPkg::byteT'($random(seed)));
    finishTest("parallel load");

    for (int i = 0; i < 8; i++) begin
      newBit       = 1'($random(seed));
      serialSwitch = newBit;
      settle();
      checkOutputs("data switch change");
      sclkSwitch = 1'b1;
      settle();
      expValue = {expValue[midpointPkg::ByteWidth-2:0], newBit};
      checkOutputs("serial clock rise");
      sclkSwitch = 1'b0;
      settle();
      checkOutputs("serial clock fall");
    end
    finishTest("serial shift");

    loadValue  = ~expValue;  // A stray load would show up
    loadButton = 1'b1;
    repeat (midpointPkg::DebounceCycles - 2) @(negedge trigger);
    loadButton = 1'b0;
    settle();
    checkOutputs("short load press");
    sclkSwitch = 1'b1;
    repeat (midpointPkg::DebounceCycles - 2) @(negedge trigger);
    sclkSwitch = 1'b0;
    settle();
    checkOutputs("short serial clock pulse");
    finishTest("glitch rejection");

    showHighButton = 1'b1;
    settle();
    expSelect = 1'b1;
    checkOutputs("show high pressed");
    showHighButton = 1'b0;
    settle();
    checkOutputs("show high released");
    pressLoad(midpointPkg::byteT'($random(seed)));  // Select holds across a load
    showLowButton = 1'b1;
    settle();
    expSelect = 1'b0;
    checkOutputs("show low pressed");
    showLowButton = 1'b0;
    settle();
    checkOutputs("show low released");
    pressLoad(midpointPkg::byteT'($random(seed)));
    finishTest("display select");

    $display("Checks passed %0d, failed %0d", checkCount - errorCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/midpointTop_chk.sv
// ----------------------------------------------------------
// Checker for strobe width and shift register update rules
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module midpointTopChk (
  input logic                     trigger,
  input logic                     rstN,
  input midpointPkg::conditionedT loadCond,
  input midpointPkg::conditionedT dataCond,
  input midpointPkg::conditionedT sclkCond,
  input midpointPkg::conditionedT showHighCond,
  input midpointPkg::conditionedT showLowCond,
  input midpointPkg::byteT        loadValue,
  input midpointPkg::byteT        registerValue
);

  logic [4:0] rises;  // One strobe per conditioner
  logic [4:0] falls;

  assign rises = {loadCond.rise, dataCond.rise, sclkCond.rise,
                  showHighCond.rise, showLowCond.rise};
  assign falls = {loadCond.fall, dataCond.fall, sclkCond.fall,
                  showHighCond.fall, showLowCond.fall};

  // ----------------------------------------------------------
  // Strobes never last two cycles
  // ----------------------------------------------------------
  strobeWidth: assert property (@(posedge trigger) disable iff (!rstN)
    ((rises & $past(rises)) == 5'd0) && ((falls & $past(falls)) == 5'd0))
    else $error("Conditioner strobe held high for more than one cycle");

  // Load pulse takes the parallel value on the next edge
  loadUpdate: assert property (@(posedge trigger) disable iff (!rstN)
    loadCond.rise |=> (registerValue == $past(loadValue)))
    else $error("Register did not take loadValue after a load pulse");

  // Shift without load moves left and fills bit 0 from the data switch
  shiftUpdate: assert property (@(posedge trigger) disable iff (!rstN)
    (sclkCond.rise && !loadCond.rise) |=>
      (registerValue == {$past(registerValue[midpointPkg::ByteWidth-2:0]),
                         $past(dataCond.level)}))
    else $error("Register did not shift after a serial clock pulse");

endmodule

`default_nettype wire

//--- vlog.f
source/midpointPkg.sv
source/debounceTimer.sv
source/inputConditioner.sv
source/shiftRegister.sv
source/displayDriver.sv
source/midpointTop.sv
verification/midpointTop_chk.sv
verification/midpointTb.sv
